// File: list.f
+incdir+source
source/cart_cpu_pkg.sv
source/cart_host_pkg.sv
source/cartridge_cpu_port.sv
source/cartridge_host_port.sv
source/cartridge_rom_core.sv
source/cartridge_rom_top.sv
verif/cartridge_rom_sva.sv
verif/cartridge_rom_tb.sv

// File: source/cart_cpu_pkg.sv
`include "cart_macros.svh"

package cart_cpu_pkg;

   ////////////////////////////////////////
   // CPU side access request
   ////////////////////////////////////////

   typedef logic [`CART_CPU_AW-1:0] cpu_addr_t;

   // One CPU strobe, decoded into what it asks of the array and the bank.
   typedef struct packed {
      logic                      rd;       // Array read through the window.
      logic                      ram_we;   // Write into the RAM region.
      logic                      bank_we;  // Bank switch.
      logic                      bank;     // New bank value.
      logic [`CART_ARRAY_AW-1:0] waddr;    // Array address of the RAM write.
      cpu_addr_t                 offset;   // Offset inside the 8K window.
      logic [`CART_BYTE_W-1:0]   wdata;    // Byte to write.
   } cpu_req_t;

endpackage

// File: source/cart_host_pkg.sv
`include "cart_macros.svh"

package cart_host_pkg;

   ////////////////////////////////////////
   // Control register
   ////////////////////////////////////////

   typedef struct packed {
      logic [2:0] zero_hi;   // Reads as zero.
      logic       bank;      // Selected 8K bank.
      logic [1:0] zero_lo;   // Reads as zero.
      logic       mm;        // RAM region is writable.
      logic       banked;    // Bank switching enabled.
   } cart_ctrl_t;

   ////////////////////////////////////////
   // Host data and requests
   ////////////////////////////////////////

   typedef logic [`CART_HOST_AW-1:0] host_adr_t;

   // The host data byte is a control word or a plain array byte,
   // depending on the address it goes to.
   typedef union packed {
      cart_ctrl_t              ctrl;
      logic [`CART_BYTE_W-1:0] raw;
   } host_word_u;

   // Array access the host asks for in this cycle.
   typedef struct packed {
      logic                      rd;
      logic                      we;
      logic [`CART_ARRAY_AW-1:0] addr;
      logic [`CART_BYTE_W-1:0]   wdata;   // Byte for an array write.
   } host_req_t;

endpackage

// File: source/cart_macros.svh
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

////////////////////////////////////////
// Array sizing
////////////////////////////////////////

`define CART_ARRAY_DEPTH 16384

`define CART_ARRAY_AW 14

// The writable region is the upper 4K of the lower 8K bank.
`define CART_RAM_AW 12

`define CART_BYTE_W 8

////////////////////////////////////////
// Bus address widths
////////////////////////////////////////

`define CART_CPU_AW 13

// The top bit selects the array, the low bits address it.
`define CART_HOST_AW 21

`endif

// File: source/cartridge_cpu_port.sv
`include "cart_macros.svh"

module cartridge_cpu_port
   import cart_cpu_pkg::*;
   import cart_host_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    cs_i,
   input  logic                    we_i,
   input  logic [`CART_CPU_AW-1:0] addr_i,
   input  logic [`CART_BYTE_W-1:0] data_i,
   input  cart_ctrl_t              ctrl_i,
   output cpu_req_t                req_o
);

   logic run_q;
   logic stb;

   // Strobes are ignored until the first cycle after reset is released.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         run_q <= 1'b0;
      end else begin
         run_q <= 1'b1;
      end
   end

   assign stb = cs_i & run_q;

   ////////////////////////////////////////
   // Request decode
   ////////////////////////////////////////

   always_comb begin
      req_o         = '0;
      req_o.rd      = stb & ~we_i;
      req_o.ram_we  = stb & we_i & ctrl_i.mm & addr_i[`CART_CPU_AW-1];
      req_o.bank_we = stb & we_i & ctrl_i.banked;
      req_o.bank    = addr_i[1];   // Bank value comes from address bit 1.
      req_o.waddr   = {{(`CART_ARRAY_AW-`CART_RAM_AW-1){1'b0}}, 1'b1,
                       addr_i[`CART_RAM_AW-1:0]};
      req_o.offset  = addr_i;
      req_o.wdata   = data_i;
   end

endmodule

// File: source/cartridge_host_port.sv
`include "cart_macros.svh"

module cartridge_host_port
   import cart_host_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  host_adr_t               adr_i,
   input  host_word_u              dat_i,
   input  logic                    we_i,
   input  logic                    sel_i,
   input  logic                    stb_i,
   input  logic                    cyc_i,
   output logic [`CART_BYTE_W-1:0] dat_o,
   output logic                    ack_o,
   input  logic                    cpu_bank_we_i,
   input  logic                    cpu_bank_i,
   input  logic                    grant_i,
   input  logic [`CART_BYTE_W-1:0] rdata_i,
   output cart_ctrl_t              ctrl_o,
   output host_req_t               req_o
);

   logic mm_q;
   logic banked_q;
   logic bank_q;
   logic access;
   logic ctrl_sel;
   logic ctrl_we;

   // No new access is presented in the ack cycle itself.
   assign access   = cyc_i & stb_i & ~ack_o;
   assign ctrl_sel = ~adr_i[`CART_HOST_AW-1];
   assign ctrl_we  = access & ctrl_sel & we_i & sel_i;

   ////////////////////////////////////////
   // Array requests
   ////////////////////////////////////////

   always_comb begin
      req_o       = '0;
      req_o.rd    = access & ~ctrl_sel & ~we_i;
      req_o.we    = access & ~ctrl_sel & we_i & sel_i;
      req_o.addr  = adr_i[`CART_ARRAY_AW-1:0];
      req_o.wdata = dat_i.raw;
   end

   ////////////////////////////////////////
   // Control register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         mm_q     <= 1'b0;
         banked_q <= 1'b0;
         bank_q   <= 1'b0;
      end else if (ctrl_we) begin
         mm_q     <= dat_i.ctrl.mm;
         banked_q <= dat_i.ctrl.banked;
         bank_q   <= dat_i.ctrl.bank & dat_i.ctrl.banked;   // Unbanked forces bank 0.
      end else if (cpu_bank_we_i) begin
         bank_q <= cpu_bank_i;
      end
   end

   always_comb begin
      ctrl_o        = '0;
      ctrl_o.mm     = mm_q;
      ctrl_o.banked = banked_q;
      ctrl_o.bank   = bank_q;
   end

   ////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////

   // A blocked array access gets no ack, so the host keeps its strobe.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access & grant_i;
      end
   end

   assign dat_o = ctrl_sel ? ctrl_o : rdata_i;

endmodule

// File: source/cartridge_rom_core.sv
`include "cart_macros.svh"

module cartridge_rom_core
   import cart_cpu_pkg::*;
   import cart_host_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  cpu_req_t                cpu_req_i,
   input  host_req_t               host_req_i,
   input  cart_ctrl_t              ctrl_i,
   output logic [`CART_BYTE_W-1:0] rdata_o,
   output logic                    grant_o
);

   logic [`CART_BYTE_W-1:0]   mem [`CART_ARRAY_DEPTH];
   logic [`CART_ARRAY_AW-1:0] raddr;
   logic [`CART_ARRAY_AW-1:0] waddr;
   logic [`CART_BYTE_W-1:0]   wdata;
   logic                      rd_en;
   logic                      wr_en;
   logic                      rd_clash;
   logic                      wr_clash;

   ////////////////////////////////////////
   // Arbitration
   ////////////////////////////////////////

   // The CPU always wins its port, the host waits.
   assign rd_clash = cpu_req_i.rd & host_req_i.rd;
   assign wr_clash = cpu_req_i.ram_we & host_req_i.we;
   assign grant_o  = ~(rd_clash | wr_clash);

   always_comb begin
      if (cpu_req_i.rd) begin
         raddr = {ctrl_i.bank, cpu_req_i.offset};   // Bank picks the 8K half.
      end else begin
         raddr = host_req_i.addr;
      end
   end

   always_comb begin
      if (cpu_req_i.ram_we) begin
         waddr = cpu_req_i.waddr;
         wdata = cpu_req_i.wdata;
      end else begin
         waddr = host_req_i.addr;
         wdata = host_req_i.wdata;
      end
   end

   assign rd_en = cpu_req_i.rd | host_req_i.rd;
   assign wr_en = cpu_req_i.ram_we | host_req_i.we;

   ////////////////////////////////////////
   // Array
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[waddr] <= wdata;
      end
   end

   // The read register keeps its byte until the next read.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         rdata_o <= '0;
      end else if (rd_en) begin
         rdata_o <= mem[raddr];
      end
   end

endmodule

// File: source/cartridge_rom_top.sv
`include "cart_macros.svh"

module cartridge_rom_top
   import cart_cpu_pkg::*;
   import cart_host_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n_i,

   // CPU side.
   input  logic                    cpu_cs_i,
   input  logic                    cpu_we_i,
   input  logic [`CART_CPU_AW-1:0] cpu_addr_i,
   input  logic [`CART_BYTE_W-1:0] cpu_data_i,
   output logic [`CART_BYTE_W-1:0] cpu_data_o,

   // Host loader bus.
   input  host_adr_t               host_adr_i,
   input  logic [`CART_BYTE_W-1:0] host_dat_i,
   input  logic                    host_we_i,
   input  logic                    host_sel_i,
   input  logic                    host_stb_i,
   input  logic                    host_cyc_i,
   output logic [`CART_BYTE_W-1:0] host_dat_o,
   output logic                    host_ack_o
);

   cpu_req_t   cpu_req;
   host_req_t  host_req;
   cart_ctrl_t ctrl;
   logic       host_grant;

   cartridge_cpu_port cpu_port_i (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .cs_i    (cpu_cs_i),
      .we_i    (cpu_we_i),
      .addr_i  (cpu_addr_i),
      .data_i  (cpu_data_i),
      .ctrl_i  (ctrl),
      .req_o   (cpu_req)
   );

   cartridge_host_port host_port_i (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .adr_i         (host_adr_i),
      .dat_i         (host_dat_i),
      .we_i          (host_we_i),
      .sel_i         (host_sel_i),
      .stb_i         (host_stb_i),
      .cyc_i         (host_cyc_i),
      .dat_o         (host_dat_o),
      .ack_o         (host_ack_o),
      .cpu_bank_we_i (cpu_req.bank_we),
      .cpu_bank_i    (cpu_req.bank),
      .grant_i       (host_grant),
      .rdata_i       (cpu_data_o),
      .ctrl_o        (ctrl),
      .req_o         (host_req)
   );

   cartridge_rom_core core_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .cpu_req_i  (cpu_req),
      .host_req_i (host_req),
      .ctrl_i     (ctrl),
      .rdata_o    (cpu_data_o),
      .grant_o    (host_grant)
   );

endmodule

// File: verif/cartridge_rom_sva.sv
module cartridge_rom_sva (
   input logic clk,
   input logic rst_n_i,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i
);

   int unsigned fail_count = 0;

   ////////////////////////////////////////
   // Host handshake
   ////////////////////////////////////////

   ack_single: assert property (@(posedge clk) disable iff (!rst_n_i) ack_i |=> !ack_i)
      else begin
         fail_count++;
         $error("ack high for two cycles in a row");
      end

   ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
                                   ack_i |-> $past(cyc_i && stb_i))
      else begin
         fail_count++;
         $error("ack without a preceding strobe");
      end

   ack_reset: assert property (@(posedge clk) !rst_n_i |=> !ack_i)
      else begin
         fail_count++;
         $error("ack high after reset");
      end

endmodule

bind cartridge_host_port cartridge_rom_sva sva_i (
   .clk     (clk),
   .rst_n_i (rst_n_i),
   .cyc_i   (cyc_i),
   .stb_i   (stb_i),
   .ack_i   (ack_o)
);

// File: verif/cartridge_rom_tb.sv
`include "cart_macros.svh"

module cartridge_rom_tb
   import cart_cpu_pkg::*;
   import cart_host_pkg::*;
();

   logic                    clk = 1'b0;
   logic                    rst_n;
   logic                    cpu_cs;
   logic                    cpu_we;
   cpu_addr_t               cpu_addr;
   logic [`CART_BYTE_W-1:0] cpu_data;
   logic [`CART_BYTE_W-1:0] cpu_rdata;
   host_adr_t               host_adr;
   logic [`CART_BYTE_W-1:0] host_dat;
   logic                    host_we;
   logic                    host_sel;
   logic                    host_stb;
   logic                    host_cyc;
   logic [`CART_BYTE_W-1:0] host_rdata;
   logic                    host_ack;

   logic [`CART_BYTE_W-1:0] model_mem [`CART_ARRAY_DEPTH];
   cart_ctrl_t              model_ctrl;
   int unsigned             seed_val;

   always #20 clk = ~clk;

   cartridge_rom_top dut_i (
      .clk        (clk),
      .rst_n_i    (rst_n),
      .cpu_cs_i   (cpu_cs),
      .cpu_we_i   (cpu_we),
      .cpu_addr_i (cpu_addr),
      .cpu_data_i (cpu_data),
      .cpu_data_o (cpu_rdata),
      .host_adr_i (host_adr),
      .host_dat_i (host_dat),
      .host_we_i  (host_we),
      .host_sel_i (host_sel),
      .host_stb_i (host_stb),
      .host_cyc_i (host_cyc),
      .host_dat_o (host_rdata),
      .host_ack_o (host_ack)
   );

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input logic [`CART_BYTE_W-1:0] got,
                             input logic [`CART_BYTE_W-1:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_ctrl(input string name, input cart_ctrl_t got, input cart_ctrl_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   always @(negedge clk) begin
      if (dut_i.host_port_i.sva_i.fail_count != 0) begin
         stop_on_error("Handshake assertions failed during the run.");
      end
   end

   ////////////////////////////////////////
   // Bus drivers and model
   ////////////////////////////////////////

   function automatic host_adr_t array_adr(input logic [`CART_ARRAY_AW-1:0] addr);
      array_adr                     = '0;
      array_adr[`CART_HOST_AW-1]    = 1'b1;   // Top bit selects the array.
      array_adr[`CART_ARRAY_AW-1:0] = addr;
   endfunction

   task automatic host_access(input logic we, input host_adr_t adr,
                              input logic [`CART_BYTE_W-1:0] wdat,
                              output logic [`CART_BYTE_W-1:0] rdat);
      int waited;
      @(posedge clk);
      host_cyc <= 1'b1;
      host_stb <= 1'b1;
      host_we  <= we;
      host_sel <= 1'b1;
      host_adr <= adr;
      host_dat <= wdat;
      waited = 0;
      @(negedge clk);
      while (host_ack !== 1'b1) begin
         waited++;
         if (waited > 20) begin
            stop_on_error("Host cycle was not acknowledged within 20 cycles.");
         end
         @(negedge clk);
      end
      rdat = host_rdata;
      @(posedge clk);
      host_cyc <= 1'b0;
      host_stb <= 1'b0;
   endtask

   task automatic write_array(input logic [`CART_ARRAY_AW-1:0] addr,
                              input logic [`CART_BYTE_W-1:0] data);
      logic [`CART_BYTE_W-1:0] rdat;
      host_access(1'b1, array_adr(addr), data, rdat);
      model_mem[addr] = data;
   endtask

   task automatic read_array(input logic [`CART_ARRAY_AW-1:0] addr);
      logic [`CART_BYTE_W-1:0] rdat;
      host_access(1'b0, array_adr(addr), '0, rdat);
      check_byte("host_dat_o", rdat, model_mem[addr]);
   endtask

   task automatic write_ctrl(input logic [`CART_BYTE_W-1:0] value);
      cart_ctrl_t              c;
      logic [`CART_BYTE_W-1:0] rdat;
      c = value;
      host_access(1'b1, '0, value, rdat);
      model_ctrl        = '0;
      model_ctrl.mm     = c.mm;
      model_ctrl.banked = c.banked;
      if (c.banked) begin
         model_ctrl.bank = c.bank;   // Unbanked mode pins bank 0.
      end
   endtask

   task automatic read_ctrl();
      logic [`CART_BYTE_W-1:0] rdat;
      host_access(1'b0, '0, '0, rdat);
      check_ctrl("host_dat_o", rdat, model_ctrl);
   endtask

   task automatic cpu_access(input logic we, input cpu_addr_t addr,
                             input logic [`CART_BYTE_W-1:0] data);
      logic [`CART_BYTE_W-1:0] expected;
      expected = model_mem[{model_ctrl.bank, addr}];
      @(posedge clk);
      cpu_cs   <= 1'b1;
      cpu_we   <= we;
      cpu_addr <= addr;
      cpu_data <= data;
      @(posedge clk);
      cpu_cs <= 1'b0;
      if (we) begin
         if (model_ctrl.mm && addr[`CART_CPU_AW-1]) begin
            model_mem[14'd4096 + addr[11:0]] = data;
         end
         if (model_ctrl.banked) begin
            model_ctrl.bank = addr[1];
         end
      end else begin
         @(negedge clk);
         check_byte("cpu_data_o", cpu_rdata, expected);
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      logic [`CART_ARRAY_AW-1:0] addr;
      logic [`CART_ARRAY_AW-1:0] written [$];
      cpu_addr_t                 offset;
      seed_val = $urandom(32'h0c44_14d7);
      model_ctrl = '0;
      rst_n    <= 1'b0;
      cpu_cs   <= 1'b0;
      cpu_we   <= 1'b0;
      cpu_addr <= '0;
      cpu_data <= '0;
      host_adr <= '0;
      host_dat <= '0;
      host_we  <= 1'b0;
      host_sel <= 1'b0;
      host_stb <= 1'b0;
      host_cyc <= 1'b0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      read_ctrl();

      for (int a = 0; a < `CART_ARRAY_DEPTH; a++) begin
         addr = a;
         write_array(addr, addr[7:0] ^ addr[13:6]);   // Pattern covers all address bits.
      end
      repeat (64) begin
         addr = $urandom;
         write_array(addr, $urandom);
         written.push_back(addr);
      end
      foreach (written[i]) read_array(written[i]);
      repeat (32) read_array($urandom);

      write_ctrl(8'h10);   // Bank bit without banked mode.
      read_ctrl();
      repeat (16) begin
         write_ctrl($urandom);
         read_ctrl();
      end

      write_ctrl(8'h11);
      repeat (64) cpu_access(1'b0, $urandom, '0);
      repeat (48) begin
         write_ctrl($urandom);
         offset = $urandom;
         cpu_access(1'b1, offset, $urandom);
         read_array(14'd4096 + offset[11:0]);
         read_ctrl();
         cpu_access(1'b0, $urandom, '0);
      end

      // CPU reads bank 0 and writes the RAM region. The host writes only
      // bank 1 and reads outside the RAM region.
      write_ctrl(8'h02);
      fork
         repeat (200) begin
            repeat ($urandom_range(2)) @(posedge clk);
            cpu_access($urandom_range(1), $urandom, $urandom);
         end
         repeat (100) begin
            addr = $urandom;
            if ($urandom_range(1)) begin
               write_array({1'b1, addr[12:0]}, $urandom);
            end else if (addr[13:12] == 2'b01) begin
               read_array({2'b11, addr[11:0]});
            end else begin
               read_array(addr);
            end
         end
      join

      if (dut_i.host_port_i.sva_i.fail_count != 0) begin
         stop_on_error("Handshake assertions failed during the run.");
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule
